// File: include/tb_vb_checks.svh
// reference models and compare task that the data entry testbench includes in its top module
`ifndef TB_VB_CHECKS_SVH
`define TB_VB_CHECKS_SVH

  // position of the single set bit of a one-hot select
  function automatic int onehot_pos(input vb_data_pkg::beat_sel_t sel);
    int pos;
    pos = 0;
    for (int i = 0; i < vb_data_pkg::beats_per_line; i++)
    begin
      if (sel[i])
        pos = i;
    end
    return pos;
  endfunction

  // beat n of the line sits at bits n*128 upward
  function automatic vb_data_pkg::beat_t ref_wb_beat(input vb_data_pkg::line_t line,
                                                     input vb_data_pkg::beat_sel_t sel);
    return line[onehot_pos(sel)*vb_data_pkg::beat_w +: vb_data_pkg::beat_w];
  endfunction

  // snoop index counts from the start beat given by the order
  function automatic vb_data_pkg::beat_t ref_snoop_beat(input vb_data_pkg::line_t line,
                                                        input vb_data_pkg::order_t order,
                                                        input vb_data_pkg::beat_sel_t index);
    int pos;
    pos = (onehot_pos(index) + int'(order)) % vb_data_pkg::beats_per_line;
    return line[pos*vb_data_pkg::beat_w +: vb_data_pkg::beat_w];
  endfunction

  // half that the first borrow writes
  // upper half first only for a snoop with order[1] set
  function automatic int ref_fill(input vb_data_pkg::order_t order, input logic is_snoop);
    return (is_snoop && order[1]) ? 1 : 0;
  endfunction

  task automatic check_value(input vb_data_pkg::beat_t got, input vb_data_pkg::beat_t exp,
                             input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t ns: %s, expected %0h, got %0h", $time, what, exp, got);
    end
  endtask

`endif

// File: bench/tb_vb_data_entry.sv
// testbench for the victim-buffer data entry that run.sh compiles from build.f and runs
`timescale 1ns/10ps

module tb_vb_data_entry;

  localparam int clk_period   = 10;
  // cycle budgets per test that size the watchdog
  localparam int reset_cycles = 8;
  localparam int wb_cycles    = 24;
  localparam int wait_cycles  = 16;
  localparam int sdb_cycles   = 16;
  localparam int total_cycles = reset_cycles + 3 * wb_cycles + wait_cycles + 4 * sdb_cycles;

  logic                   vb_data_entry_clk;
  logic                   cpurst_b;
  logic                   create_vld;
  logic                   create_dp_vld;
  logic                   dcache_dirty;
  vb_data_pkg::addr_id_t  rcl_addr_id;
  logic                   ld_da_borrow;
  vb_data_pkg::half_t     ld_da_data256;
  logic                   set_data_done;
  logic                   biu_req_success;
  logic                   wd_sm_grnt;
  vb_data_pkg::beat_sel_t wd_sm_data_bias;
  logic                   wd_sm_data_pop_req;
  logic                   sdb_create_en;
  vb_data_pkg::order_t    sdb_create_data_order;
  vb_data_pkg::beat_sel_t sdb_entry_data_index;
  logic                   sdb_inv_en;
  logic                   vb_data_entry_vld;
  logic                   vb_data_entry_dirty;
  vb_data_pkg::addr_id_t  vb_data_entry_addr_id;
  logic                   vb_data_entry_biu_req;
  logic                   vb_data_entry_wd_sm_req;
  vb_data_pkg::beat_t     vb_data_entry_write_data128;
  logic                   vb_data_entry_normal_pop;
  logic                   sdb_vld;
  logic                   sdb_data_vld;
  logic                   sdb_entry_avail;
  logic                   vb_sdb_data_entry_vld;
  vb_data_pkg::beat_t     sdb_entry_data;

  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;

  `include "tb_vb_checks.svh"

  vb_data_entry i_vb_data_entry (.*);

  initial
  begin
    vb_data_entry_clk = 1'b0;
    forever #(clk_period / 2) vb_data_entry_clk = ~vb_data_entry_clk;
  end

  //============================================================
  // watchdog
  //============================================================
  initial
  begin
    #(2 * total_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", 2 * total_cycles);
    $display("Some tests failed");
    $finish;
  end

  function automatic vb_data_pkg::half_t rand_half();
    vb_data_pkg::half_t v;
    for (int i = 0; i < 8; i++)
      v[i*32 +: 32] = $urandom();
    return v;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
  endtask

  // one-cycle fill pulse from the load pipeline
  task automatic borrow(input vb_data_pkg::half_t h);
    @(posedge vb_data_entry_clk);
    ld_da_borrow  <= 1'b1;
    ld_da_data256 <= h;
    @(posedge vb_data_entry_clk);
    ld_da_borrow  <= 1'b0;
  endtask

  //============================================================
  // writeback flow with optional back-pressure and snoop create
  //============================================================
  task automatic wb_flow(input int addr_wait, input int data_wait, input logic with_sdb);
    vb_data_pkg::half_t     h0;
    vb_data_pkg::half_t     h1;
    vb_data_pkg::line_t     exp_line;
    vb_data_pkg::beat_sel_t sel;
    logic [31:0]            r;
    int                     first;
    h0 = rand_half();
    h1 = rand_half();
    r  = $urandom();
    @(posedge vb_data_entry_clk);
    create_vld            <= 1'b1;
    create_dp_vld         <= 1'b1;
    dcache_dirty          <= r[0];
    rcl_addr_id           <= r[2:1];
    sdb_create_en         <= with_sdb;
    sdb_create_data_order <= 2'b11;
    @(negedge vb_data_entry_clk);
    check_value(128'(sdb_entry_avail), 128'd0, "avail low while create_vld high");
    @(posedge vb_data_entry_clk);
    create_vld    <= 1'b0;
    create_dp_vld <= 1'b0;
    sdb_create_en <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_data_entry_vld), 128'd1, "vld after create");
    check_value(128'(sdb_vld), 128'd0, "writeback wins over snoop create");
    borrow(h0);
    borrow(h1);
    set_data_done <= 1'b1;
    @(posedge vb_data_entry_clk);
    set_data_done <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_data_entry_biu_req), 128'd1, "biu_req after done");
    repeat (addr_wait)
    begin
      @(negedge vb_data_entry_clk);
      check_value(128'(vb_data_entry_biu_req), 128'd1, "biu_req held");
    end
    @(posedge vb_data_entry_clk);
    biu_req_success <= 1'b1;
    @(posedge vb_data_entry_clk);
    biu_req_success <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_data_entry_biu_req), 128'd0, "biu_req drops after success");
    check_value(128'(vb_data_entry_wd_sm_req), 128'd1, "wd_sm_req after success");
    repeat (data_wait)
    begin
      @(negedge vb_data_entry_clk);
      check_value(128'(vb_data_entry_wd_sm_req), 128'd1, "wd_sm_req held");
    end
    @(posedge vb_data_entry_clk);
    wd_sm_grnt <= 1'b1;
    @(posedge vb_data_entry_clk);
    wd_sm_grnt <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_data_entry_wd_sm_req), 128'd0, "wd_sm_req drops after grant");
    check_value(128'(vb_data_entry_dirty), 128'(r[0]), "captured dirty");
    check_value(128'(vb_data_entry_addr_id), 128'(r[2:1]), "captured addr id");
    // a writeback never swaps, whatever order was driven with the create
    first = ref_fill(2'b11, 1'b0);
    exp_line[first*vb_data_pkg::half_w +: vb_data_pkg::half_w]     = h0;
    exp_line[(1-first)*vb_data_pkg::half_w +: vb_data_pkg::half_w] = h1;
    for (int b = 0; b < vb_data_pkg::beats_per_line; b++)
    begin
      sel    = '0;
      sel[b] = 1'b1;
      @(posedge vb_data_entry_clk);
      wd_sm_data_bias <= sel;
      @(negedge vb_data_entry_clk);
      check_value(vb_data_entry_write_data128, ref_wb_beat(exp_line, sel),
                  $sformatf("write beat %0d", b));
    end
    @(posedge vb_data_entry_clk);
    wd_sm_data_pop_req <= 1'b1;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_data_entry_normal_pop), 128'd1, "normal_pop during pop");
    @(posedge vb_data_entry_clk);
    wd_sm_data_pop_req <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_data_entry_vld), 128'd0, "vld low after pop");
  endtask

  //============================================================
  // snoop data buffer flow
  //============================================================
  task automatic sdb_flow(input vb_data_pkg::order_t ord);
    vb_data_pkg::half_t     h0;
    vb_data_pkg::half_t     h1;
    vb_data_pkg::line_t     exp_line;
    vb_data_pkg::beat_sel_t sel;
    int                     first;
    h0 = rand_half();
    h1 = rand_half();
    @(posedge vb_data_entry_clk);
    sdb_create_en         <= 1'b1;
    sdb_create_data_order <= ord;
    @(posedge vb_data_entry_clk);
    sdb_create_en <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(sdb_vld), 128'd1, "sdb_vld after create");
    check_value(128'(sdb_data_vld), 128'd0, "sdb_data_vld before fill");
    check_value(128'(sdb_entry_avail), 128'd0, "avail low while buffer busy");
    borrow(h0);
    @(negedge vb_data_entry_clk);
    check_value(128'(sdb_data_vld), 128'd1, "sdb_data_vld after first borrow");
    borrow(h1);
    first = ref_fill(ord, 1'b1);
    exp_line[first*vb_data_pkg::half_w +: vb_data_pkg::half_w]       = h0;
    exp_line[(1-first)*vb_data_pkg::half_w +: vb_data_pkg::half_w]   = h1;
    for (int b = 0; b < vb_data_pkg::beats_per_line; b++)
    begin
      sel    = '0;
      sel[b] = 1'b1;
      @(posedge vb_data_entry_clk);
      sdb_entry_data_index <= sel;
      @(negedge vb_data_entry_clk);
      check_value(sdb_entry_data, ref_snoop_beat(exp_line, ord, sel),
                  $sformatf("snoop index %0d", b));
    end
    @(posedge vb_data_entry_clk);
    sdb_inv_en <= 1'b1;
    @(posedge vb_data_entry_clk);
    sdb_inv_en <= 1'b0;
    @(negedge vb_data_entry_clk);
    check_value(128'(vb_sdb_data_entry_vld), 128'd0, "entry idle after inv");
    check_value(128'(sdb_entry_avail), 128'd1, "avail after inv");
  endtask

  //============================================================
  // test sequence
  //============================================================
  initial
  begin
    int errs_before;
    void'($urandom(9971));
    err_cnt               = 0;
    chk_cnt               = 0;
    test_cnt              = 0;
    cpurst_b              = 1'b0;
    create_vld            = 1'b0;
    create_dp_vld         = 1'b0;
    dcache_dirty          = 1'b0;
    rcl_addr_id           = '0;
    ld_da_borrow          = 1'b0;
    ld_da_data256         = '0;
    set_data_done         = 1'b0;
    biu_req_success       = 1'b0;
    wd_sm_grnt            = 1'b0;
    wd_sm_data_bias       = '0;
    wd_sm_data_pop_req    = 1'b0;
    sdb_create_en         = 1'b0;
    sdb_create_data_order = '0;
    sdb_entry_data_index  = '0;
    sdb_inv_en            = 1'b0;
    repeat (5) @(posedge vb_data_entry_clk);
    cpurst_b <= 1'b1;
    @(negedge vb_data_entry_clk);
    errs_before = err_cnt;
    check_value(128'(vb_data_entry_vld), 128'd0, "vld after reset");
    check_value(128'(vb_data_entry_biu_req), 128'd0, "biu_req after reset");
    check_value(128'(vb_data_entry_wd_sm_req), 128'd0, "wd_sm_req after reset");
    check_value(128'(sdb_vld), 128'd0, "sdb_vld after reset");
    check_value(128'(sdb_data_vld), 128'd0, "sdb_data_vld after reset");
    check_value(128'(sdb_entry_avail), 128'd1, "avail after reset");
    report_test("reset outputs", errs_before);
    errs_before = err_cnt;
    wb_flow(0, 0, 1'b0);
    report_test("writeback line", errs_before);
    errs_before = err_cnt;
    wb_flow($urandom_range(1, 8), $urandom_range(1, 8), 1'b0);
    report_test("writeback back-pressure", errs_before);
    errs_before = err_cnt;
    wb_flow(0, 0, 1'b1);
    report_test("create priority", errs_before);
    for (int o = 0; o < 4; o++)
    begin
      errs_before = err_cnt;
      sdb_flow(2'(o));
      report_test($sformatf("snoop order %0d", o), errs_before);
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
logic/vb_data_pkg.sv
logic/vb_ctrl_pkg.sv
logic/vb_entry_fsm.sv
logic/vb_fill_sequencer.sv
logic/vb_line_store.sv
logic/vb_beat_select.sv
logic/vb_data_entry.sv
bench/tb_vb_data_entry.sv

// File: logic/vb_beat_select.sv
// beat readout of the stored line for the write-data channel and the snoop data channel
`timescale 1ns/10ps

module vb_beat_select (
  input  vb_data_pkg::line_t     line_data,
  input  vb_data_pkg::beat_sel_t wd_sm_data_bias,
  input  vb_data_pkg::beat_sel_t sdb_entry_data_index,
  input  vb_data_pkg::order_t    start_order,
  output vb_data_pkg::beat_t     write_data128,
  output vb_data_pkg::beat_t     sdb_entry_data
);

  vb_data_pkg::beat_sel_t snoop_sel;

  // and-or mux, select is one-hot
  function automatic vb_data_pkg::beat_t pick_beat(
    input vb_data_pkg::line_t     line,
    input vb_data_pkg::beat_sel_t sel
  );
    vb_data_pkg::beat_t acc;
    acc = '0;
    for (int i = 0; i < vb_data_pkg::beats_per_line; i++)
    begin
      acc = acc | ({vb_data_pkg::beat_w{sel[i]}}
                   & line[i*vb_data_pkg::beat_w +: vb_data_pkg::beat_w]);
    end
    return acc;
  endfunction

  //==========================================================
  // writeback beat
  //==========================================================
  assign write_data128 = pick_beat(line_data, wd_sm_data_bias);

  //==========================================================
  // snoop beat
  //==========================================================
  // index counts from the start beat, rotate left by the order
  assign snoop_sel = (sdb_entry_data_index << start_order)
                     | (sdb_entry_data_index >> (vb_data_pkg::beats_per_line - start_order));

  assign sdb_entry_data = pick_beat(line_data, snoop_sel);

endmodule

// File: logic/vb_ctrl_pkg.sv
// entry state encoding and state decode helpers for the victim-buffer data entry FSM
package vb_ctrl_pkg;

  localparam int state_w = 4;

  // bit 3 marks writeback, bits 3:2 == 01 marks snoop buffer
  typedef enum logic [state_w-1:0] {
    idle            = 4'b0000,
    get_vb_data     = 4'b1000,
    req_write_addr  = 4'b1001,
    req_write_data  = 4'b1010,
    grnt_write_data = 4'b1011,
    get_snq_data    = 4'b0100,
    req_cd_channel  = 4'b0101
  } entry_state_e;

  // writeback flow active
  function automatic logic is_writeback(input entry_state_e s);
    return s[3];
  endfunction

  // snoop data buffer active
  function automatic logic is_snoop_buf(input entry_state_e s);
    return (s[3:2] == 2'b01);
  endfunction

  // either flow holds the entry
  function automatic logic is_busy(input entry_state_e s);
    return |s[3:2];
  endfunction

endpackage

// File: logic/vb_data_entry.sv
// victim-buffer data entry top, connects FSM, fill sequencer, line store and beat readout
`timescale 1ns/10ps

module vb_data_entry (
  input  logic                   vb_data_entry_clk,
  input  logic                   cpurst_b,
  // create
  input  logic                   create_vld,
  input  logic                   create_dp_vld,
  input  logic                   dcache_dirty,
  input  vb_data_pkg::addr_id_t  rcl_addr_id,
  // fill from load pipeline
  input  logic                   ld_da_borrow,
  input  vb_data_pkg::half_t     ld_da_data256,
  input  logic                   set_data_done,
  // writeback handshakes
  input  logic                   biu_req_success,
  input  logic                   wd_sm_grnt,
  input  vb_data_pkg::beat_sel_t wd_sm_data_bias,
  input  logic                   wd_sm_data_pop_req,
  // snoop data buffer
  input  logic                   sdb_create_en,
  input  vb_data_pkg::order_t    sdb_create_data_order,
  input  vb_data_pkg::beat_sel_t sdb_entry_data_index,
  input  logic                   sdb_inv_en,
  // entry status
  output logic                   vb_data_entry_vld,
  output logic                   vb_data_entry_dirty,
  output vb_data_pkg::addr_id_t  vb_data_entry_addr_id,
  output logic                   vb_data_entry_biu_req,
  output logic                   vb_data_entry_wd_sm_req,
  output vb_data_pkg::beat_t     vb_data_entry_write_data128,
  output logic                   vb_data_entry_normal_pop,
  // snoop status and data
  output logic                   sdb_vld,
  output logic                   sdb_data_vld,
  output logic                   sdb_entry_avail,
  output logic                   vb_sdb_data_entry_vld,
  output vb_data_pkg::beat_t     sdb_entry_data
);

  vb_data_pkg::half_sel_t half_wr_en;
  vb_data_pkg::order_t    start_order;
  vb_data_pkg::line_t     line_data;

  //==========================================================
  // control
  //==========================================================
  vb_entry_fsm i_vb_entry_fsm (
    .vb_data_entry_clk  (vb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .create_vld         (create_vld),
    .sdb_create_en      (sdb_create_en),
    .set_data_done      (set_data_done),
    .biu_req_success    (biu_req_success),
    .wd_sm_grnt         (wd_sm_grnt),
    .wd_sm_data_pop_req (wd_sm_data_pop_req),
    .ld_da_borrow       (ld_da_borrow),
    .sdb_inv_en         (sdb_inv_en),
    .entry_vld          (vb_data_entry_vld),
    .sdb_vld            (sdb_vld),
    .sdb_data_vld       (sdb_data_vld),
    .sdb_entry_avail    (sdb_entry_avail),
    .sdb_data_entry_vld (vb_sdb_data_entry_vld),
    .biu_req            (vb_data_entry_biu_req),
    .wd_sm_req          (vb_data_entry_wd_sm_req),
    .normal_pop         (vb_data_entry_normal_pop)
  );

  vb_fill_sequencer i_vb_fill_sequencer (
    .vb_data_entry_clk     (vb_data_entry_clk),
    .cpurst_b              (cpurst_b),
    .create_dp_vld         (create_dp_vld),
    .sdb_create_en         (sdb_create_en),
    .sdb_create_data_order (sdb_create_data_order),
    .ld_da_borrow          (ld_da_borrow),
    .sdb_vld               (sdb_vld),
    .half_wr_en            (half_wr_en),
    .start_order           (start_order)
  );

  //==========================================================
  // data
  //==========================================================
  vb_line_store i_vb_line_store (
    .vb_data_entry_clk (vb_data_entry_clk),
    .cpurst_b          (cpurst_b),
    .half_wr_en        (half_wr_en),
    .ld_da_data256     (ld_da_data256),
    .create_dp_vld     (create_dp_vld),
    .dcache_dirty      (dcache_dirty),
    .rcl_addr_id       (rcl_addr_id),
    .line_data         (line_data),
    .entry_dirty       (vb_data_entry_dirty),
    .entry_addr_id     (vb_data_entry_addr_id)
  );

  vb_beat_select i_vb_beat_select (
    .line_data            (line_data),
    .wd_sm_data_bias      (wd_sm_data_bias),
    .sdb_entry_data_index (sdb_entry_data_index),
    .start_order          (start_order),
    .write_data128        (vb_data_entry_write_data128),
    .sdb_entry_data       (sdb_entry_data)
  );

endmodule

// File: logic/vb_data_pkg.sv
// line, half and beat widths plus vector types shared by the victim-buffer data entry
package vb_data_pkg;

  //==========================================================
  // widths
  //==========================================================
  localparam int beat_w          = 128;
  localparam int half_w          = 256;
  localparam int line_w          = 512;
  localparam int beats_per_line  = line_w / beat_w;
  localparam int halves_per_line = line_w / half_w;

  //==========================================================
  // vector types
  //==========================================================
  // whole cache line, beat 0 in the low bits
  typedef logic [line_w-1:0]          line_t;

  // one fill from the load pipeline
  typedef logic [half_w-1:0]          half_t;

  // one write-data or snoop-data beat
  typedef logic [beat_w-1:0]          beat_t;

  // one-hot beat select, also the snoop read index
  typedef logic [beats_per_line-1:0]  beat_sel_t;

  // one-hot half pointer / half write enables
  typedef logic [halves_per_line-1:0] half_sel_t;

  // snoop start order, upper bit picks the critical half
  typedef logic [1:0]                 order_t;

  // address-entry id
  typedef logic [1:0]                 addr_id_t;

endpackage

// File: logic/vb_entry_fsm.sv
// entry FSM sequencing the writeback and snoop-buffer flows and decoding their status
`timescale 1ns/10ps

module vb_entry_fsm (
  input  logic vb_data_entry_clk,
  input  logic cpurst_b,
  input  logic create_vld,
  input  logic sdb_create_en,
  input  logic set_data_done,
  input  logic biu_req_success,
  input  logic wd_sm_grnt,
  input  logic wd_sm_data_pop_req,
  input  logic ld_da_borrow,
  input  logic sdb_inv_en,
  output logic entry_vld,
  output logic sdb_vld,
  output logic sdb_data_vld,
  output logic sdb_entry_avail,
  output logic sdb_data_entry_vld,
  output logic biu_req,
  output logic wd_sm_req,
  output logic normal_pop
);

  vb_ctrl_pkg::entry_state_e state_q;
  vb_ctrl_pkg::entry_state_e state_d;

  //==========================================================
  // state register
  //==========================================================
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state_q <= vb_ctrl_pkg::idle;
    else
      state_q <= state_d;
  end

  //==========================================================
  // next state
  //==========================================================
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      vb_ctrl_pkg::idle:
        // evicted line wins over a snoop create
        if (create_vld)
          state_d = vb_ctrl_pkg::get_vb_data;
        else if (sdb_create_en)
          state_d = vb_ctrl_pkg::get_snq_data;
      vb_ctrl_pkg::get_vb_data:
        if (set_data_done)
          state_d = vb_ctrl_pkg::req_write_addr;
      vb_ctrl_pkg::req_write_addr:
        if (biu_req_success)
          state_d = vb_ctrl_pkg::req_write_data;
      vb_ctrl_pkg::req_write_data:
        if (wd_sm_grnt)
          state_d = vb_ctrl_pkg::grnt_write_data;
      vb_ctrl_pkg::grnt_write_data:
        if (wd_sm_data_pop_req)
          state_d = vb_ctrl_pkg::idle;
      // first half in is enough to start the snoop data channel
      vb_ctrl_pkg::get_snq_data:
        if (ld_da_borrow)
          state_d = vb_ctrl_pkg::req_cd_channel;
      vb_ctrl_pkg::req_cd_channel:
        if (sdb_inv_en)
          state_d = vb_ctrl_pkg::idle;
      default:
        state_d = vb_ctrl_pkg::idle;
    endcase
  end

  //==========================================================
  // status decode
  //==========================================================
  assign entry_vld          = vb_ctrl_pkg::is_writeback(state_q);
  assign sdb_vld            = vb_ctrl_pkg::is_snoop_buf(state_q);
  assign sdb_data_entry_vld = vb_ctrl_pkg::is_busy(state_q);
  assign sdb_data_vld       = (state_q == vb_ctrl_pkg::req_cd_channel);

  // a pending create already claims the entry
  assign sdb_entry_avail    = !sdb_data_entry_vld && !create_vld;

  // requests held until their handshake
  assign biu_req            = (state_q == vb_ctrl_pkg::req_write_addr);
  assign wd_sm_req          = (state_q == vb_ctrl_pkg::req_write_data);

  assign normal_pop         = (state_q == vb_ctrl_pkg::grnt_write_data)
                              && wd_sm_data_pop_req;

endmodule

// File: logic/vb_fill_sequencer.sv
// half pointer and snoop start order that steer each borrow into one half of the line
`timescale 1ns/10ps

module vb_fill_sequencer (
  input  logic                  vb_data_entry_clk,
  input  logic                  cpurst_b,
  input  logic                  create_dp_vld,
  input  logic                  sdb_create_en,
  input  vb_data_pkg::order_t   sdb_create_data_order,
  input  logic                  ld_da_borrow,
  input  logic                  sdb_vld,
  output vb_data_pkg::half_sel_t half_wr_en,
  output vb_data_pkg::order_t   start_order
);

  vb_data_pkg::half_sel_t half_ptr_q;
  vb_data_pkg::half_sel_t half_ptr_eff;
  logic                   crit_swap;

  //==========================================================
  // half pointer
  //==========================================================
  // one-hot, restarts at half 0 on either create
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      half_ptr_q <= 2'b01;
    else if (create_dp_vld || sdb_create_en)
      half_ptr_q <= 2'b01;
    else if (ld_da_borrow)
      half_ptr_q <= {half_ptr_q[0], half_ptr_q[1]};
  end

  //==========================================================
  // snoop start order
  //==========================================================
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      start_order <= '0;
    else if (sdb_create_en)
      start_order <= sdb_create_data_order;
  end

  // critical half first when the order points at the upper half
  assign crit_swap    = sdb_vld && start_order[1];

  assign half_ptr_eff = crit_swap ? {half_ptr_q[0], half_ptr_q[1]} : half_ptr_q;

  assign half_wr_en   = {2{ld_da_borrow}} & half_ptr_eff;

endmodule

// File: logic/vb_line_store.sv
// line storage for the entry plus the dirty bit and address id captured at create
`timescale 1ns/10ps

module vb_line_store (
  input  logic                   vb_data_entry_clk,
  input  logic                   cpurst_b,
  input  vb_data_pkg::half_sel_t half_wr_en,
  input  vb_data_pkg::half_t     ld_da_data256,
  input  logic                   create_dp_vld,
  input  logic                   dcache_dirty,
  input  vb_data_pkg::addr_id_t  rcl_addr_id,
  output vb_data_pkg::line_t     line_data,
  output logic                   entry_dirty,
  output vb_data_pkg::addr_id_t  entry_addr_id
);

  vb_data_pkg::half_t half_q [vb_data_pkg::halves_per_line];

  //==========================================================
  // line halves
  //==========================================================
  for (genvar h = 0; h < vb_data_pkg::halves_per_line; h++)
  begin : g_half
    always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
    begin
      if (!cpurst_b)
        half_q[h] <= '0;
      else if (half_wr_en[h])
        half_q[h] <= ld_da_data256;
    end
  end

  // half 0 holds beats 0 and 1
  assign line_data = {half_q[1], half_q[0]};

  //==========================================================
  // entry attributes
  //==========================================================
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_dirty   <= 1'b0;
      entry_addr_id <= '0;
    end
    else if (create_dp_vld)
    begin
      entry_dirty   <= dcache_dirty;
      entry_addr_id <= rcl_addr_id;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, then judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_vb_data_entry -f build.f -o tb_vb_data_entry
./obj_dir/tb_vb_data_entry | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"
